/* axi_bridge_pkg.sv */
// shared bus constants, payload structs and the AR/AW beat formatter
// 32-bit address and data only, strobe width follows the data width
// a line burst is always whole 32-bit beats, INCR
// a single transfer is one FIXED beat at the requester's own size
`default_nettype none

package axi_bridge_pkg;

    // bus geometry
    parameter int ADDR_WIDTH = 32;
    parameter int DATA_WIDTH = 32;
    parameter int LEN_WIDTH  = 8;
    parameter int STRB_WIDTH = DATA_WIDTH / 8;

    // burst type codes
    parameter logic [1:0] BURST_FIXED = 2'b00;
    parameter logic [1:0] BURST_INCR  = 2'b01;

    // 4 bytes per beat
    parameter logic [2:0] SIZE_WORD = 3'b010;

    // cache-side read request, size is log2 of bytes
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [1:0]            size;
        logic                  line;
    } rd_req_t;

    // cache-side write request, line data travels beside it
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [1:0]            size;
        logic [STRB_WIDTH-1:0] strb;
        logic                  line;
    } wr_req_t;

    // AR or AW address beat
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [LEN_WIDTH-1:0]  len;
        logic [2:0]            size;
        logic [1:0]            burst;
    } ax_t;

    // R beat as seen by the requester
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  last;
    } r_beat_t;

    // W beat
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        logic                  last;
    } w_beat_t;

    // line request -> aligned INCR of full words
    // single request -> one FIXED beat, own size
    function automatic ax_t format_ax(
        input logic [ADDR_WIDTH-1:0] addr,
        input logic [1:0]            size,
        input logic                  line,
        input logic [ADDR_WIDTH-1:0] line_mask,
        input logic [LEN_WIDTH-1:0]  line_len
    );
        ax_t ax;
        if (line) begin
            ax.addr  = addr & line_mask;
            ax.len   = line_len;
            ax.size  = SIZE_WORD;
            ax.burst = BURST_INCR;
        end else begin
            ax.addr  = addr;
            ax.len   = '0;
            ax.size  = {1'b0, size};
            ax.burst = BURST_FIXED;
        end
        return ax;
    endfunction

endpackage

`default_nettype wire

/* read_arbiter.sv */
// shared AR channel for the instruction and data requesters
// data port wins a same-cycle tie, one read outstanding at a time
// R is always accepted, there is no rready and no back-pressure
// no grant while the write engine is busy
// words per line must be a power of two, 2 to 16
`timescale 1ns/1ps
`default_nettype none

module read_arbiter #(
    parameter int I_WORDS_PER_LINE = 4,
    parameter int D_WORDS_PER_LINE = 4
) (
    input  wire                      clk,
    input  wire                      reset,

    // instruction requester
    input  wire                      i_inst_rd_req,
    input  wire axi_bridge_pkg::rd_req_t i_inst_rd,

    // data requester
    input  wire                      i_data_rd_req,
    input  wire axi_bridge_pkg::rd_req_t i_data_rd,

    // from the write engine
    input  wire                      i_wr_idle,

    output logic                     o_inst_rd_rdy,
    output logic                     o_data_rd_rdy,

    // AR channel
    output logic                     o_ar_valid,
    output axi_bridge_pkg::ax_t      o_ar,
    input  wire                      i_ar_ready,

    // R channel
    input  wire                      i_r_valid,
    input  wire axi_bridge_pkg::r_beat_t i_r,

    // returned beats, owner only
    output logic                     o_inst_ret_valid,
    output axi_bridge_pkg::r_beat_t  o_inst_ret,
    output logic                     o_data_ret_valid,
    output axi_bridge_pkg::r_beat_t  o_data_ret
);

    // byte offset bits of a line, per port
    localparam int WORD_BITS = $clog2(axi_bridge_pkg::STRB_WIDTH);
    localparam int I_LINE_BITS = $clog2(I_WORDS_PER_LINE) + WORD_BITS;
    localparam int D_LINE_BITS = $clog2(D_WORDS_PER_LINE) + WORD_BITS;

    localparam logic [axi_bridge_pkg::ADDR_WIDTH-1:0] I_LINE_MASK =
        {axi_bridge_pkg::ADDR_WIDTH{1'b1}} << I_LINE_BITS;
    localparam logic [axi_bridge_pkg::ADDR_WIDTH-1:0] D_LINE_MASK =
        {axi_bridge_pkg::ADDR_WIDTH{1'b1}} << D_LINE_BITS;

    // AxLEN is beats minus one
    localparam logic [axi_bridge_pkg::LEN_WIDTH-1:0] I_LINE_LEN =
        axi_bridge_pkg::LEN_WIDTH'(I_WORDS_PER_LINE - 1);
    localparam logic [axi_bridge_pkg::LEN_WIDTH-1:0] D_LINE_LEN =
        axi_bridge_pkg::LEN_WIDTH'(D_WORDS_PER_LINE - 1);

    logic r_end;
    logic allow_ar;
    logic grant_data;
    logic grant_inst;
    logic ar_fire;
    logic outstanding;
    // 1 = data port owns the read in flight
    logic owner_data;

    // last beat closes the current read
    assign r_end = i_r_valid & i_r.last;

    // free, or freeing this cycle, and no write in progress
    assign allow_ar = (~outstanding | r_end) & i_wr_idle;

    // data first
    assign grant_data = allow_ar & i_data_rd_req;
    assign grant_inst = allow_ar & i_inst_rd_req & ~i_data_rd_req;

    assign o_ar_valid = grant_data | grant_inst;
    assign ar_fire    = o_ar_valid & i_ar_ready;

    // acceptance is the AR handshake cycle
    assign o_data_rd_rdy = grant_data & i_ar_ready;
    assign o_inst_rd_rdy = grant_inst & i_ar_ready;

    // burst shape from the granted port
    assign o_ar = grant_data ?
        axi_bridge_pkg::format_ax(i_data_rd.addr, i_data_rd.size, i_data_rd.line,
                                  D_LINE_MASK, D_LINE_LEN) :
        axi_bridge_pkg::format_ax(i_inst_rd.addr, i_inst_rd.size, i_inst_rd.line,
                                  I_LINE_MASK, I_LINE_LEN);

    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 1'b0;
            owner_data  <= 1'b0;
        end else begin
            // a new AR in the last-beat cycle keeps the flag set
            if (ar_fire) begin
                outstanding <= 1'b1;
                owner_data  <= grant_data;
            end else if (r_end) begin
                outstanding <= 1'b0;
            end
        end
    end

    // beats pass straight through, valid only toward the owner
    // owner still the old one during a back-to-back last beat
    assign o_inst_ret       = i_r;
    assign o_data_ret       = i_r;
    assign o_inst_ret_valid = i_r_valid & outstanding & ~owner_data;
    assign o_data_ret_valid = i_r_valid & outstanding & owner_data;

endmodule

`default_nettype wire

/* line_write_engine.sv */
// data-side write path, one write at a time, AW then W then B
// line write is an aligned INCR of whole words with all strobes set
// single write is one FIXED beat carrying word 0 of the line vector
// request and line data are captured on acceptance
// words per line must be a power of two, 2 to 16
`timescale 1ns/1ps
`default_nettype none

module line_write_engine #(
    parameter int D_WORDS_PER_LINE = 4
) (
    input  wire                      clk,
    input  wire                      reset,

    // cache-side request
    input  wire                      i_wr_req,
    input  wire axi_bridge_pkg::wr_req_t i_wr,
    input  wire [D_WORDS_PER_LINE*axi_bridge_pkg::DATA_WIDTH-1:0] i_wr_line,
    output logic                     o_wr_rdy,
    // to the read arbiter
    output logic                     o_wr_idle,

    // AW channel
    output logic                     o_aw_valid,
    output axi_bridge_pkg::ax_t      o_aw,
    input  wire                      i_aw_ready,

    // W channel
    output logic                     o_w_valid,
    output axi_bridge_pkg::w_beat_t  o_w,
    input  wire                      i_w_ready,

    // B channel
    input  wire                      i_b_valid,
    output logic                     o_b_ready
);

    localparam int LINE_WIDTH = D_WORDS_PER_LINE * axi_bridge_pkg::DATA_WIDTH;
    localparam int CNT_WIDTH  = $clog2(D_WORDS_PER_LINE);
    localparam int LINE_BITS  = CNT_WIDTH + $clog2(axi_bridge_pkg::STRB_WIDTH);

    localparam logic [axi_bridge_pkg::ADDR_WIDTH-1:0] LINE_MASK =
        {axi_bridge_pkg::ADDR_WIDTH{1'b1}} << LINE_BITS;
    localparam logic [axi_bridge_pkg::LEN_WIDTH-1:0] LINE_LEN =
        axi_bridge_pkg::LEN_WIDTH'(D_WORDS_PER_LINE - 1);
    localparam logic [CNT_WIDTH-1:0] LAST_BEAT = CNT_WIDTH'(D_WORDS_PER_LINE - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_RESP
    } state_t;

    state_t                   state;
    axi_bridge_pkg::wr_req_t  req_q;
    // lowest word always at the bottom, shifted down per beat
    logic [LINE_WIDTH-1:0]    line_buf;
    logic [CNT_WIDTH-1:0]     beat_cnt;
    logic                     accept;
    logic                     w_fire;

    assign o_wr_rdy  = (state == ST_IDLE);
    assign o_wr_idle = (state == ST_IDLE);
    assign accept    = i_wr_req & o_wr_rdy;

    assign o_aw_valid = (state == ST_ADDR);
    assign o_w_valid  = (state == ST_DATA);
    assign o_b_ready  = (state == ST_RESP);
    assign w_fire     = o_w_valid & i_w_ready;

    // address beat from the captured request
    assign o_aw = axi_bridge_pkg::format_ax(req_q.addr, req_q.size, req_q.line,
                                            LINE_MASK, LINE_LEN);

    // data beat
    assign o_w.data = line_buf[axi_bridge_pkg::DATA_WIDTH-1:0];
    assign o_w.strb = req_q.line ? {axi_bridge_pkg::STRB_WIDTH{1'b1}} : req_q.strb;
    // single write is its own last beat
    assign o_w.last = ~req_q.line | (beat_cnt == LAST_BEAT);

    // control
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state    <= ST_ADDR;
                        beat_cnt <= '0;
                    end
                end
                ST_ADDR: begin
                    if (i_aw_ready) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (w_fire) begin
                        if (o_w.last) begin
                            state <= ST_RESP;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                ST_RESP: begin
                    // idle again the cycle after B
                    if (i_b_valid) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // payload capture and beat shifting
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q    <= i_wr;
            line_buf <= i_wr_line;
        end else if (w_fire) begin
            line_buf <= line_buf >> axi_bridge_pkg::DATA_WIDTH;
        end
    end

endmodule

`default_nettype wire

/* axi_bridge.sv */
// two cache-side requesters onto one AXI-style bus
// reads shared between instruction and data ports, data port first
// writes from the data port only, reads held off while a write runs
// fixed AXI id, lock, cache and prot are left to the interconnect
// no rid, rresp, bid or bresp, a response error goes unnoticed
`timescale 1ns/1ps
`default_nettype none

module axi_bridge #(
    parameter int I_WORDS_PER_LINE = 4,
    parameter int D_WORDS_PER_LINE = 4
) (
    input  wire                      clk,
    input  wire                      reset,

    // instruction read port
    input  wire                      i_inst_rd_req,
    input  wire axi_bridge_pkg::rd_req_t i_inst_rd,
    output logic                     o_inst_rd_rdy,
    output logic                     o_inst_ret_valid,
    output axi_bridge_pkg::r_beat_t  o_inst_ret,

    // data read port
    input  wire                      i_data_rd_req,
    input  wire axi_bridge_pkg::rd_req_t i_data_rd,
    output logic                     o_data_rd_rdy,
    output logic                     o_data_ret_valid,
    output axi_bridge_pkg::r_beat_t  o_data_ret,

    // data write port, word 0 in the low bits
    input  wire                      i_data_wr_req,
    input  wire axi_bridge_pkg::wr_req_t i_data_wr,
    input  wire [D_WORDS_PER_LINE*axi_bridge_pkg::DATA_WIDTH-1:0] i_data_wr_line,
    output logic                     o_data_wr_rdy,

    // AR / R
    output logic                     o_ar_valid,
    output axi_bridge_pkg::ax_t      o_ar,
    input  wire                      i_ar_ready,
    input  wire                      i_r_valid,
    input  wire axi_bridge_pkg::r_beat_t i_r,

    // AW / W / B
    output logic                     o_aw_valid,
    output axi_bridge_pkg::ax_t      o_aw,
    input  wire                      i_aw_ready,
    output logic                     o_w_valid,
    output axi_bridge_pkg::w_beat_t  o_w,
    input  wire                      i_w_ready,
    input  wire                      i_b_valid,
    output logic                     o_b_ready
);

    // write engine idle, blocks new reads when low
    wire wr_idle;

    read_arbiter #(
        .I_WORDS_PER_LINE (I_WORDS_PER_LINE),
        .D_WORDS_PER_LINE (D_WORDS_PER_LINE)
    ) u_read_arbiter (
        .clk              (clk),
        .reset            (reset),
        .i_inst_rd_req    (i_inst_rd_req),
        .i_inst_rd        (i_inst_rd),
        .i_data_rd_req    (i_data_rd_req),
        .i_data_rd        (i_data_rd),
        .i_wr_idle        (wr_idle),
        .o_inst_rd_rdy    (o_inst_rd_rdy),
        .o_data_rd_rdy    (o_data_rd_rdy),
        .o_ar_valid       (o_ar_valid),
        .o_ar             (o_ar),
        .i_ar_ready       (i_ar_ready),
        .i_r_valid        (i_r_valid),
        .i_r              (i_r),
        .o_inst_ret_valid (o_inst_ret_valid),
        .o_inst_ret       (o_inst_ret),
        .o_data_ret_valid (o_data_ret_valid),
        .o_data_ret       (o_data_ret)
    );

    line_write_engine #(
        .D_WORDS_PER_LINE (D_WORDS_PER_LINE)
    ) u_line_write_engine (
        .clk              (clk),
        .reset            (reset),
        .i_wr_req         (i_data_wr_req),
        .i_wr             (i_data_wr),
        .i_wr_line        (i_data_wr_line),
        .o_wr_rdy         (o_data_wr_rdy),
        .o_wr_idle        (wr_idle),
        .o_aw_valid       (o_aw_valid),
        .o_aw             (o_aw),
        .i_aw_ready       (i_aw_ready),
        .o_w_valid        (o_w_valid),
        .o_w              (o_w),
        .i_w_ready        (i_w_ready),
        .i_b_valid        (i_b_valid),
        .o_b_ready        (o_b_ready)
    );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
// free-running testbench clock, starts low
// half period in ns, 20 gives a 40 ns clock
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_PERIOD_NS = 20
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

/* tb_axi_bridge.sv */
// random instruction/data requesters against a responsive AXI slave model
// inputs change on the rising edge, outputs are checked on the falling edge
// read data is taken from the model memory when the AR handshake fires
// writes reach the model memory at the B handshake
// instruction lines are 8 words, data lines 4 words
`timescale 1ns/1ps
`default_nettype none

module tb_axi_bridge;

    localparam int I_WPL      = 8;
    localparam int D_WPL      = 4;
    localparam int LINE_W     = D_WPL * 32;
    localparam int NUM_TXN    = 300;
    localparam int MAX_CYCLES = NUM_TXN * 64;

    // small window so reads often hit written words
    localparam logic [31:0] ADDR_BASE = 32'h0000_4000;
    localparam logic [31:0] ADDR_SPAN = 32'h0000_03ff;

    // write phases of the model, same order as the engine
    localparam logic [1:0] PH_IDLE = 2'd0;
    localparam logic [1:0] PH_ADDR = 2'd1;
    localparam logic [1:0] PH_DATA = 2'd2;
    localparam logic [1:0] PH_RESP = 2'd3;

    logic clk;
    logic reset;

    // DUT inputs
    logic                    inst_rd_req;
    axi_bridge_pkg::rd_req_t inst_rd;
    logic                    data_rd_req;
    axi_bridge_pkg::rd_req_t data_rd;
    logic                    data_wr_req;
    axi_bridge_pkg::wr_req_t data_wr;
    logic [LINE_W-1:0]       data_wr_line;
    logic                    ar_ready;
    logic                    r_valid;
    axi_bridge_pkg::r_beat_t r;
    logic                    aw_ready;
    logic                    w_ready;
    logic                    b_valid;

    // DUT outputs
    logic                    inst_rd_rdy;
    logic                    inst_ret_valid;
    axi_bridge_pkg::r_beat_t inst_ret;
    logic                    data_rd_rdy;
    logic                    data_ret_valid;
    axi_bridge_pkg::r_beat_t data_ret;
    logic                    data_wr_rdy;
    logic                    ar_valid;
    axi_bridge_pkg::ax_t     ar;
    logic                    aw_valid;
    axi_bridge_pkg::ax_t     aw;
    logic                    w_valid;
    axi_bridge_pkg::w_beat_t w;
    logic                    b_ready;

    // values for the next rising edge
    logic                    nx_inst_rd_req;
    axi_bridge_pkg::rd_req_t nx_inst_rd;
    logic                    nx_data_rd_req;
    axi_bridge_pkg::rd_req_t nx_data_rd;
    logic                    nx_data_wr_req;
    axi_bridge_pkg::wr_req_t nx_data_wr;
    logic [LINE_W-1:0]       nx_data_wr_line;
    logic                    nx_ar_ready;
    logic                    nx_r_valid;
    axi_bridge_pkg::r_beat_t nx_r;
    logic                    nx_aw_ready;
    logic                    nx_w_ready;
    logic                    nx_b_valid;

    // slave model state
    logic [31:0]             mem [logic [29:0]];
    axi_bridge_pkg::r_beat_t r_q [$];
    logic                    rd_busy;
    logic                    rd_owner_data;
    logic [1:0]              wphase;
    axi_bridge_pkg::wr_req_t wr_cur;
    logic [LINE_W-1:0]       wr_line_cur;
    int                      w_idx;

    integer seed = 32'hb6e0_f835;
    int     cycles;
    int     issued;
    int     done;

    tb_clk_gen #(.HALF_PERIOD_NS(20)) u_clk_gen (.o_clk(clk));

    axi_bridge #(
        .I_WORDS_PER_LINE (I_WPL),
        .D_WORDS_PER_LINE (D_WPL)
    ) DUT (
        .clk              (clk),
        .reset            (reset),
        .i_inst_rd_req    (inst_rd_req),
        .i_inst_rd        (inst_rd),
        .o_inst_rd_rdy    (inst_rd_rdy),
        .o_inst_ret_valid (inst_ret_valid),
        .o_inst_ret       (inst_ret),
        .i_data_rd_req    (data_rd_req),
        .i_data_rd        (data_rd),
        .o_data_rd_rdy    (data_rd_rdy),
        .o_data_ret_valid (data_ret_valid),
        .o_data_ret       (data_ret),
        .i_data_wr_req    (data_wr_req),
        .i_data_wr        (data_wr),
        .i_data_wr_line   (data_wr_line),
        .o_data_wr_rdy    (data_wr_rdy),
        .o_ar_valid       (ar_valid),
        .o_ar             (ar),
        .i_ar_ready       (ar_ready),
        .i_r_valid        (r_valid),
        .i_r              (r),
        .o_aw_valid       (aw_valid),
        .o_aw             (aw),
        .i_aw_ready       (aw_ready),
        .o_w_valid        (w_valid),
        .o_w              (w),
        .i_w_ready        (w_ready),
        .i_b_valid        (b_valid),
        .o_b_ready        (b_ready)
    );

    task automatic compare_values(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // unwritten words, odd multiplier spreads every address bit
    function automatic logic [31:0] fill_word(input logic [29:0] waddr);
        return ({2'b00, waddr} * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [31:0] mem_word(input logic [29:0] waddr);
        if (mem.exists(waddr)) begin
            return mem[waddr];
        end
        return fill_word(waddr);
    endfunction

    // expected AR/AW beat for a request
    function automatic axi_bridge_pkg::ax_t expect_ax(input logic [31:0] addr,
        input logic [1:0] size, input logic line, input int wpl);
        axi_bridge_pkg::ax_t ax;
        if (line) begin
            ax.addr  = addr & ~(32'(wpl) * 32'd4 - 32'd1);
            ax.len   = 8'(wpl - 1);
            ax.size  = 3'b010;
            ax.burst = 2'b01;
        end else begin
            ax.addr  = addr;
            ax.len   = 8'd0;
            ax.size  = {1'b0, size};
            ax.burst = 2'b00;
        end
        return ax;
    endfunction

    // snapshot of the words a read returns, in beat order
    task automatic queue_read(input axi_bridge_pkg::rd_req_t req, input int wpl);
        axi_bridge_pkg::ax_t     ax;
        axi_bridge_pkg::r_beat_t beat;
        int                      n;
        ax = expect_ax(req.addr, req.size, req.line, wpl);
        n  = req.line ? wpl : 1;
        for (int k = 0; k < n; k++) begin
            beat.data = mem_word(ax.addr[31:2] + 30'(k));
            beat.last = (k == n - 1);
            r_q.push_back(beat);
        end
    endtask

    task automatic make_rd_req(output axi_bridge_pkg::rd_req_t req);
        logic [1:0] sz;
        sz = 2'($random(seed) & 3);
        if (sz == 2'd3) begin
            sz = 2'd2;
        end
        req.addr = ADDR_BASE | (32'($random(seed)) & ADDR_SPAN);
        req.size = sz;
        req.line = ($random(seed) & 1) != 0;
    endtask

    task automatic make_wr_req(output axi_bridge_pkg::wr_req_t req,
                               output logic [LINE_W-1:0] line);
        req.addr = ADDR_BASE | (32'($random(seed)) & ADDR_SPAN);
        req.size = 2'd2;
        req.strb = 4'($random(seed));
        // single write with no byte enabled would change nothing
        if (req.strb == 4'h0) begin
            req.strb = 4'h1;
        end
        req.line = ($random(seed) & 1) != 0;
        for (int k = 0; k < D_WPL; k++) begin
            line[k*32 +: 32] = $random(seed);
        end
    endtask

    // memory update at B
    task automatic apply_write();
        axi_bridge_pkg::ax_t ax;
        logic [31:0]         word;
        ax = expect_ax(wr_cur.addr, wr_cur.size, wr_cur.line, D_WPL);
        if (wr_cur.line) begin
            for (int k = 0; k < D_WPL; k++) begin
                mem[ax.addr[31:2] + 30'(k)] = wr_line_cur[k*32 +: 32];
            end
        end else begin
            word = mem_word(ax.addr[31:2]);
            for (int b = 0; b < 4; b++) begin
                if (wr_cur.strb[b]) begin
                    word[b*8 +: 8] = wr_line_cur[b*8 +: 8];
                end
            end
            mem[ax.addr[31:2]] = word;
        end
    endtask

    initial begin
        axi_bridge_pkg::r_beat_t beat;
        axi_bridge_pkg::w_beat_t wexp;
        logic                    allow;
        logic                    g_data;
        logic                    g_inst;

        inst_rd_req  = 1'b0;
        inst_rd      = '0;
        data_rd_req  = 1'b0;
        data_rd      = '0;
        data_wr_req  = 1'b0;
        data_wr      = '0;
        data_wr_line = '0;
        ar_ready     = 1'b0;
        r_valid      = 1'b0;
        r            = '0;
        aw_ready     = 1'b0;
        w_ready      = 1'b0;
        b_valid      = 1'b0;
        nx_inst_rd_req  = 1'b0;
        nx_inst_rd      = '0;
        nx_data_rd_req  = 1'b0;
        nx_data_rd      = '0;
        nx_data_wr_req  = 1'b0;
        nx_data_wr      = '0;
        nx_data_wr_line = '0;
        nx_r            = '0;
        rd_busy       = 1'b0;
        rd_owner_data = 1'b0;
        wphase        = PH_IDLE;
        w_idx         = 0;
        cycles        = 0;
        issued        = 0;
        done          = 0;

        reset = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        while (done < NUM_TXN) begin
            @(negedge clk);
            cycles++;
            if (cycles > MAX_CYCLES) begin
                $display("timeout after %0d cycles, %0d of %0d transactions done",
                         cycles, done, NUM_TXN);
                $display("STATUS: FAIL");
                $fatal(1, "timeout");
            end

            // write channel levels follow the model phase
            compare_values("o_data_wr_rdy", 64'(data_wr_rdy), 64'(wphase == PH_IDLE));
            compare_values("o_aw_valid", 64'(aw_valid), 64'(wphase == PH_ADDR));
            compare_values("o_w_valid", 64'(w_valid), 64'(wphase == PH_DATA));
            compare_values("o_b_ready", 64'(b_ready), 64'(wphase == PH_RESP));

            // returned beat, owner only
            if (r_valid) begin
                beat = r_q.pop_front();
                compare_values("o_data_ret_valid", 64'(data_ret_valid), 64'(rd_owner_data));
                compare_values("o_inst_ret_valid", 64'(inst_ret_valid), 64'(!rd_owner_data));
                if (rd_owner_data) begin
                    compare_values("o_data_ret", 64'(data_ret), 64'(beat));
                end else begin
                    compare_values("o_inst_ret", 64'(inst_ret), 64'(beat));
                end
                if (beat.last) begin
                    rd_busy = 1'b0;
                    done++;
                end
            end else begin
                compare_values("o_data_ret_valid", 64'(data_ret_valid), 64'd0);
                compare_values("o_inst_ret_valid", 64'(inst_ret_valid), 64'd0);
            end

            // AR grant, data first, none during a read or a write
            allow  = !rd_busy && (wphase == PH_IDLE);
            g_data = allow && data_rd_req;
            g_inst = allow && inst_rd_req && !data_rd_req;
            compare_values("o_ar_valid", 64'(ar_valid), 64'(g_data || g_inst));
            compare_values("o_data_rd_rdy", 64'(data_rd_rdy), 64'(g_data && ar_ready));
            compare_values("o_inst_rd_rdy", 64'(inst_rd_rdy), 64'(g_inst && ar_ready));
            if (ar_valid && ar_ready) begin
                if (g_data) begin
                    compare_values("o_ar", 64'(ar),
                        64'(expect_ax(data_rd.addr, data_rd.size, data_rd.line, D_WPL)));
                    queue_read(data_rd, D_WPL);
                    nx_data_rd_req = 1'b0;
                end else begin
                    compare_values("o_ar", 64'(ar),
                        64'(expect_ax(inst_rd.addr, inst_rd.size, inst_rd.line, I_WPL)));
                    queue_read(inst_rd, I_WPL);
                    nx_inst_rd_req = 1'b0;
                end
                rd_busy       = 1'b1;
                rd_owner_data = g_data;
            end

            // write sequence AW, W, B
            case (wphase)
                PH_IDLE: begin
                    if (data_wr_req && data_wr_rdy) begin
                        wr_cur         = data_wr;
                        wr_line_cur    = data_wr_line;
                        wphase         = PH_ADDR;
                        nx_data_wr_req = 1'b0;
                    end
                end
                PH_ADDR: begin
                    if (aw_valid && aw_ready) begin
                        compare_values("o_aw", 64'(aw),
                            64'(expect_ax(wr_cur.addr, wr_cur.size, wr_cur.line, D_WPL)));
                        wphase = PH_DATA;
                        w_idx  = 0;
                    end
                end
                PH_DATA: begin
                    if (w_valid && w_ready) begin
                        wexp.data = wr_line_cur[w_idx*32 +: 32];
                        wexp.strb = wr_cur.line ? 4'hf : wr_cur.strb;
                        wexp.last = !wr_cur.line || (w_idx == D_WPL - 1);
                        compare_values("o_w", 64'(w), 64'(wexp));
                        w_idx++;
                        if (wexp.last) begin
                            wphase = PH_RESP;
                        end
                    end
                end
                default: begin
                    if (b_ready && b_valid) begin
                        apply_write();
                        wphase = PH_IDLE;
                        done++;
                    end
                end
            endcase

            // slave side choices for the next edge
            nx_ar_ready = ($random(seed) & 3) != 0;
            nx_r_valid  = (r_q.size() != 0) && (($random(seed) & 3) != 0);
            if (nx_r_valid) begin
                nx_r = r_q[0];
            end
            nx_aw_ready = ($random(seed) & 1) != 0;
            nx_w_ready  = ($random(seed) & 3) != 0;
            nx_b_valid  = (wphase == PH_RESP) && (($random(seed) & 1) != 0);

            // new requests while the budget lasts
            if (!nx_inst_rd_req && issued < NUM_TXN && ($random(seed) & 3) == 0) begin
                make_rd_req(nx_inst_rd);
                nx_inst_rd_req = 1'b1;
                issued++;
            end
            if (!nx_data_rd_req && issued < NUM_TXN && ($random(seed) & 3) == 0) begin
                make_rd_req(nx_data_rd);
                nx_data_rd_req = 1'b1;
                issued++;
            end
            if (!nx_data_wr_req && issued < NUM_TXN && ($random(seed) & 7) == 0) begin
                make_wr_req(nx_data_wr, nx_data_wr_line);
                nx_data_wr_req = 1'b1;
                issued++;
            end

            @(posedge clk);
            inst_rd_req  <= nx_inst_rd_req;
            inst_rd      <= nx_inst_rd;
            data_rd_req  <= nx_data_rd_req;
            data_rd      <= nx_data_rd;
            data_wr_req  <= nx_data_wr_req;
            data_wr      <= nx_data_wr;
            data_wr_line <= nx_data_wr_line;
            ar_ready     <= nx_ar_ready;
            r_valid      <= nx_r_valid;
            r            <= nx_r;
            aw_ready     <= nx_aw_ready;
            w_ready      <= nx_w_ready;
            b_valid      <= nx_b_valid;
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* axi_bridge.f */
axi_bridge_pkg.sv
read_arbiter.sv
line_write_engine.sv
axi_bridge.sv
tb_clk_gen.sv
tb_axi_bridge.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, judge the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    --top-module tb_axi_bridge \
    -f axi_bridge.f \
    -o tb_axi_bridge_sim

# a failing run still leaves its log for the search below
./obj_dir/tb_axi_bridge_sim 2>&1 | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
